// ==== source/dac_ctrl_pkg.sv ====
//////////////////////////////
// shared types and constants for the AD5601 DAC control block
// SCLK_DIV must be even, the word is always sent MSB first
//////////////////////////////

package dac_ctrl_pkg;

    //////////////////////////////
    // widths and counters

    localparam int DAC_WORD_W = 16;                   // DAC command word and bus data
    localparam int DAC_GAIN_W = 8;                    // DAC code field
    localparam int REG_ADDR_W = 4;                    // register word address
    localparam int SCLK_DIV   = 4;                    // system clocks per sclk period
    localparam int DIV_CNT_W  = $clog2(SCLK_DIV);
    localparam int BIT_CNT_W  = $clog2(DAC_WORD_W);

    //////////////////////////////
    // register map and reset values

    localparam logic [REG_ADDR_W-1:0] ADDR_VERSION = 4'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_DAC     = 4'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_EN_MMI  = 4'd2;  // mirror of the control-select pin

    localparam logic [DAC_WORD_W-1:0] MODULE_VERSION = 16'd1;
    localparam logic [DAC_WORD_W-1:0] DAC_DEFAULT    = 16'd100; // sent once after reset

    //////////////////////////////
    // types

    // AD5601 input shift register layout, pd_mode sits in the top two bits
    typedef struct packed {
        logic [1:0]            pd_mode;   // power-down mode
        logic [DAC_GAIN_W-1:0] gain;      // DAC code
        logic [5:0]            rsvd;      // don't care
    } dac_fields_t;

    // bus sees the raw word, direct path only touches the gain
    typedef union packed {
        logic [DAC_WORD_W-1:0] raw;
        dac_fields_t           fields;
    } dac_word_u;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [REG_ADDR_W-1:0] adr;
        logic [DAC_WORD_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [DAC_WORD_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic sync_n;   // active-low frame
        logic sclk;     // idles high
        logic mosi;
    } spi_pins_t;

endpackage

// ==== source/dac_reg_bank.sv ====
//////////////////////////////
// Wishbone classic slave, single transfers only, ack one cycle after the request
// bus writes to the DAC word only count while en_mmi_ctrl is high
//////////////////////////////

`timescale 1ns/1ps

module dac_reg_bank import dac_ctrl_pkg::*; (
    input  logic                  clk_ifc,
    input  logic                  SET_DEFAULT_ON_RESET,
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    input  logic                  en_mmi_ctrl,
    input  logic [DAC_GAIN_W-1:0] gain,
    input  logic                  gain_valid,
    output dac_word_u             cmd,
    output logic                  cmd_valid
);

    logic                  ack_q;
    logic [DAC_WORD_W-1:0] rd_dat_q;
    logic [DAC_WORD_W-1:0] rd_mux;
    dac_word_u             word_q;
    logic                  boot_q;        // high through reset, sends the default once
    logic                  cmd_valid_q;
    logic                  bus_req;
    logic                  bus_wr_dac;
    logic                  gain_wr;

    //////////////////////////////
    // bus decode

    assign bus_req = wb_req.cyc & wb_req.stb;

    // write lands at the end of the ack cycle, master still holds adr/dat there
    assign bus_wr_dac = ack_q & bus_req & wb_req.we
                      & (wb_req.adr == ADDR_DAC) & en_mmi_ctrl;

    assign gain_wr = gain_valid & ~en_mmi_ctrl;   // strobe ignored in bus mode

    always_comb begin
        case (wb_req.adr)
            ADDR_VERSION: rd_mux = MODULE_VERSION;
            ADDR_DAC:     rd_mux = word_q.raw;
            ADDR_EN_MMI:  rd_mux = {{(DAC_WORD_W-1){1'b0}}, en_mmi_ctrl};
            default:      rd_mux = '0;            // unmapped reads zero
        endcase
    end

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req & ~ack_q;            // single-cycle ack, never back to back
        end
    end

    // read data captured with the ack
    always_ff @(posedge clk_ifc) begin
        if (bus_req & ~ack_q) begin
            rd_dat_q <= rd_mux;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_dat_q;

    //////////////////////////////
    // DAC word and command pulse

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            word_q.raw <= DAC_DEFAULT;
        end else if (bus_wr_dac) begin
            word_q.raw <= wb_req.dat;
        end else if (gain_wr) begin
            word_q.fields.gain <= gain;           // pd_mode and rsvd kept
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            boot_q      <= 1'b1;
            cmd_valid_q <= 1'b0;
        end else begin
            boot_q      <= 1'b0;
            cmd_valid_q <= boot_q | bus_wr_dac | gain_wr;
        end
    end

    // word and pulse line up in the cycle after the change
    assign cmd       = word_q;
    assign cmd_valid = cmd_valid_q;

    //////////////////////////////
    // checks

    // every ack answers a request that was there the cycle before and is still held
    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        wb_rsp.ack |-> $past(bus_req) && bus_req);

endmodule

// ==== source/dac_cmd_holder.sv ====
//////////////////////////////
// one-entry command store, a newer command overwrites a pending one
//////////////////////////////

`timescale 1ns/1ps

module dac_cmd_holder import dac_ctrl_pkg::*; (
    input  logic      clk_ifc,
    input  logic      SET_DEFAULT_ON_RESET,
    input  dac_word_u cmd,
    input  logic      cmd_valid,
    input  logic      busy,
    output logic      start,
    output dac_word_u start_word
);

    dac_word_u word_q;
    logic      full_q;

    // hand over as soon as the shifter is free
    assign start      = full_q & ~busy;
    assign start_word = word_q;

    always_ff @(posedge clk_ifc) begin
        if (cmd_valid) begin
            word_q <= cmd;                 // newest wins
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            full_q <= 1'b0;
        end else if (cmd_valid) begin
            full_q <= 1'b1;                // refill even on the start cycle
        end else if (start) begin
            full_q <= 1'b0;
        end
    end

    //////////////////////////////
    // checks

    // the shifter must take each start and report busy on the next cycle
    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        start |=> busy);

endmodule

// ==== source/dac_spi_shifter.sv ====
//////////////////////////////
// one 16-bit frame per start, start to done is 16*SCLK_DIV+2 cycles
// mosi moves on rising sclk, the DAC samples on falling sclk
//////////////////////////////

`timescale 1ns/1ps

module dac_spi_shifter import dac_ctrl_pkg::*; (
    input  logic      clk_ifc,
    input  logic      SET_DEFAULT_ON_RESET,
    input  logic      start,
    input  dac_word_u start_word,
    output logic      busy,
    output logic      done,
    output spi_pins_t spi
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SHIFT,   // 16 bit periods
        ST_HOLD,    // last sclk rise with sync still low
        ST_DONE     // sync back high
    } shift_state_t;

    shift_state_t          state_q;
    logic [DIV_CNT_W-1:0]  div_cnt_q;
    logic [BIT_CNT_W-1:0]  bit_cnt_q;
    logic [DAC_WORD_W-1:0] shreg_q;
    logic                  sync_n_q;
    logic                  sclk_q;
    logic                  div_wrap;
    logic                  last_bit;

    assign div_wrap = (div_cnt_q == DIV_CNT_W'(SCLK_DIV - 1));
    assign last_bit = (bit_cnt_q == BIT_CNT_W'(DAC_WORD_W - 1));

    //////////////////////////////
    // frame sequencer

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state_q   <= ST_IDLE;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            shreg_q   <= '0;
            sync_n_q  <= 1'b1;
            sclk_q    <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q   <= ST_SHIFT;
                        shreg_q   <= start_word.raw;   // msb on mosi right away
                        sync_n_q  <= 1'b0;
                        div_cnt_q <= '0;
                        bit_cnt_q <= '0;
                    end
                end
                ST_SHIFT: begin
                    div_cnt_q <= div_cnt_q + 1'b1;
                    if (div_cnt_q == DIV_CNT_W'(SCLK_DIV/2 - 1)) begin
                        sclk_q <= 1'b0;                // falling edge mid bit
                    end
                    if (div_wrap) begin
                        sclk_q <= 1'b1;
                        if (last_bit) begin
                            state_q <= ST_HOLD;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            shreg_q   <= {shreg_q[DAC_WORD_W-2:0], 1'b0};
                        end
                    end
                end
                ST_HOLD: begin
                    state_q  <= ST_DONE;
                    sync_n_q <= 1'b1;
                end
                default: begin
                    state_q <= ST_IDLE;                // ST_DONE
                end
            endcase
        end
    end

    assign busy = (state_q != ST_IDLE);
    assign done = (state_q == ST_DONE);

    assign spi.sync_n = sync_n_q;
    assign spi.sclk   = sclk_q;
    assign spi.mosi   = shreg_q[DAC_WORD_W-1];

    //////////////////////////////
    // checks

    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        !busy |-> spi.sync_n);

endmodule

// ==== source/dac_ad5601_ctrl.sv ====
//////////////////////////////
// AD5601 control top, one synchronous active-high reset for all blocks
//////////////////////////////

`timescale 1ns/1ps

module dac_ad5601_ctrl import dac_ctrl_pkg::*; (
    input  logic                  clk_ifc,
    input  logic                  SET_DEFAULT_ON_RESET,
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    input  logic                  en_mmi_ctrl,   // low hands the gain field to the direct path
    input  logic [DAC_GAIN_W-1:0] gain,
    input  logic                  gain_valid,
    output spi_pins_t             spi,
    output logic                  done
);

    dac_word_u cmd;
    logic      cmd_valid;
    dac_word_u start_word;
    logic      start;
    logic      busy;

    // producer, register bank
    dac_reg_bank u_reg_bank (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .wb_req               ( wb_req               ),
        .wb_rsp               ( wb_rsp               ),
        .en_mmi_ctrl          ( en_mmi_ctrl          ),
        .gain                 ( gain                 ),
        .gain_valid           ( gain_valid           ),
        .cmd                  ( cmd                  ),
        .cmd_valid            ( cmd_valid            )
    );

    // merges updates that arrive mid frame
    dac_cmd_holder u_cmd_holder (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .cmd                  ( cmd                  ),
        .cmd_valid            ( cmd_valid            ),
        .busy                 ( busy                 ),
        .start                ( start                ),
        .start_word           ( start_word           )
    );

    dac_spi_shifter u_spi_shifter (
        .clk_ifc              ( clk_ifc              ),
        .SET_DEFAULT_ON_RESET ( SET_DEFAULT_ON_RESET ),
        .start                ( start                ),
        .start_word           ( start_word           ),
        .busy                 ( busy                 ),
        .done                 ( done                 ),
        .spi                  ( spi                  )
    );

endmodule

// ==== tb/dac_tb_tasks.svh ====
//////////////////////////////
// bus and gain stimulus, every task starts and ends 1 ns after a rising clock edge
//////////////////////////////

`ifndef DAC_TB_TASKS_SVH
`define DAC_TB_TASKS_SVH

// galois LFSR, one step per bit taken
function automatic logic [15:0] lfsr_bits(input int nbits);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
        v = {v[14:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
endfunction

// one classic single transfer, held until ack and through the ack cycle
task automatic bus_xfer(input logic we, input logic [REG_ADDR_W-1:0] adr,
                        input logic [DAC_WORD_W-1:0] dat);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = dat;
    do begin
        @(posedge clk_ifc);
        #1;
    end while (!wb_rsp.ack);
    @(posedge clk_ifc);     // a write lands at the end of the ack cycle
    #1;
    wb_req = '0;
endtask

task automatic bus_write(input logic [REG_ADDR_W-1:0] adr, input logic [DAC_WORD_W-1:0] dat);
    bus_xfer(1'b1, adr, dat);
endtask

// the read data is checked against rd_exp on the ack cycle
task automatic bus_read(input logic [REG_ADDR_W-1:0] adr, input logic [DAC_WORD_W-1:0] exp);
    rd_exp = exp;
    bus_xfer(1'b0, adr, '0);
endtask

task automatic strobe_gain(input logic [DAC_GAIN_W-1:0] g);
    gain       = g;
    gain_valid = 1'b1;
    @(posedge clk_ifc);
    #1;
    gain_valid = 1'b0;
endtask

`endif

// ==== tb/dac_ad5601_ctrl_tb.sv ====
//////////////////////////////
// frames are rebuilt from the SPI pins, expected words come from a register model
//////////////////////////////

`timescale 1ns/1ps

module dac_ad5601_ctrl_tb import dac_ctrl_pkg::*; ();

    localparam int N_RAND    = 12;
    localparam int N_WR      = 4;
    localparam int N_STB     = 3;
    localparam int IDLE_CYC  = 16*SCLK_DIV + 10;  // longer than one whole frame
    localparam int FRAME_LOW = 16*SCLK_DIV + 1;   // sync_n low window, start cycle excluded
    localparam int N_OPS     = 3 + 2*N_RAND + 2*N_WR + 2 + 2*N_STB + 3 + 6;
    localparam int WD_CYC    = N_OPS*(16*SCLK_DIV + 10) + 50;

    logic                  clk_ifc;
    logic                  SET_DEFAULT_ON_RESET;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic                  en_mmi_ctrl;
    logic [DAC_GAIN_W-1:0] gain;
    logic                  gain_valid;
    spi_pins_t             spi;
    logic                  done;

    logic [15:0] lfsr;
    logic [15:0] model_word;     // newest word the DAC should end up with
    logic [15:0] exp_frame;      // word the next finished frame carries
    logic [15:0] rd_exp;
    logic [15:0] rx_shift;
    logic [15:0] rx_frame;
    logic        cnt_chk;
    int          frame_cnt = 0;
    int          exp_cnt;
    int          low_cnt = 0;
    int          frame_errs = 0;
    int          bus_errs = 0;
    int          timing_errs = 0;

    dac_ad5601_ctrl dut (.*);

    `include "dac_tb_tasks.svh"

    initial begin
        clk_ifc = 1'b0;
        forever #50 clk_ifc = ~clk_ifc;
    end

    //////////////////////////////
    // SPI receiver

    always @(negedge spi.sclk) begin
        if (!SET_DEFAULT_ON_RESET && !spi.sync_n) begin
            rx_shift <= {rx_shift[14:0], spi.mosi};   // DAC samples on falling sclk
        end
    end

    always @(posedge spi.sync_n) begin
        if (!SET_DEFAULT_ON_RESET) begin
            rx_frame  <= rx_shift;
            frame_cnt <= frame_cnt + 1;
        end
    end

    always @(posedge clk_ifc) begin
        low_cnt <= (spi.sync_n !== 1'b0) ? 0 : low_cnt + 1;
    end

    //////////////////////////////
    // checks

    a_ack: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            bus_errs++;
            $display("error %0t wb_rsp.ack: got 1 expected 0 after an ack", $time);
        end

    a_read: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        (wb_rsp.ack && !wb_req.we) |-> wb_rsp.dat == rd_exp)
        else begin
            bus_errs++;
            $display("error %0t wb_rsp.dat: got %h expected %h", $time,
                     $sampled(wb_rsp.dat), $sampled(rd_exp));
        end

    a_frame: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        done |-> rx_frame == exp_frame)
        else begin
            frame_errs++;
            $display("error %0t rx_frame: got %h expected %h", $time,
                     $sampled(rx_frame), $sampled(exp_frame));
        end

    a_count: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        cnt_chk |-> frame_cnt == exp_cnt)
        else begin
            frame_errs++;
            $display("error %0t frame_cnt: got %0d expected %0d", $time,
                     $sampled(frame_cnt), $sampled(exp_cnt));
        end

    // start cycle plus the low window gives 16*SCLK_DIV+2 cycles to done
    a_done: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        done |-> $rose(spi.sync_n) && low_cnt == FRAME_LOW)
        else begin
            timing_errs++;
            $display("error %0t sync_n low cycles at done: got %0d expected %0d", $time,
                     $sampled(low_cnt), FRAME_LOW);
        end

    a_rise: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        $rose(spi.sync_n) |-> done)
        else begin
            timing_errs++;
            $display("error %0t done: got 0 expected 1 as sync_n rose", $time);
        end

    a_low: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        !spi.sync_n |-> low_cnt < FRAME_LOW)
        else begin
            timing_errs++;
            $display("sync_n stayed low longer than one frame at %0t", $time);
        end

    a_sclk: assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        spi.sync_n |-> spi.sclk)
        else begin
            timing_errs++;
            $display("error %0t spi.sclk: got 0 expected 1 outside a frame", $time);
        end

    //////////////////////////////
    // reference model and sequencing

    function automatic logic [15:0] reg_value(input logic [REG_ADDR_W-1:0] adr);
        case (adr)
            ADDR_VERSION: return MODULE_VERSION;
            ADDR_DAC:     return model_word;
            ADDR_EN_MMI:  return {15'd0, en_mmi_ctrl};
            default:      return 16'd0;
        endcase
    endfunction

    // one extra edge so the done check sees the old exp_frame
    task automatic wait_frames(input int n);
        while (frame_cnt < n) begin
            @(posedge clk_ifc);
            #1;
        end
        @(posedge clk_ifc);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_ifc);
            #1;
        end
    endtask

    task automatic check_count(input int n);
        exp_cnt = n;
        cnt_chk = 1'b1;
        idle(1);
        cnt_chk = 1'b0;
    endtask

    initial begin
        logic [15:0]           rv;
        logic [REG_ADDR_W-1:0] adr;
        int                    base;

        SET_DEFAULT_ON_RESET = 1'b1;
        wb_req      = '0;
        en_mmi_ctrl = 1'b1;
        gain        = '0;
        gain_valid  = 1'b0;
        cnt_chk     = 1'b0;
        exp_cnt     = 0;
        rd_exp      = '0;
        rx_shift    = '0;
        rx_frame    = '0;
        lfsr        = 16'd61265;
        model_word  = DAC_DEFAULT;
        exp_frame   = DAC_DEFAULT;
        repeat (3) @(posedge clk_ifc);
        #1;
        SET_DEFAULT_ON_RESET = 1'b0;

        // default word goes out once after reset
        wait_frames(1);
        bus_read(ADDR_VERSION, reg_value(ADDR_VERSION));
        bus_read(ADDR_DAC, reg_value(ADDR_DAC));
        check_count(1);

        for (int k = 0; k < N_RAND; k++) begin
            rv  = lfsr_bits(3);
            adr = rv[REG_ADDR_W-1:0];
            if (adr != ADDR_DAC && lfsr_bits(1) != 16'd0) begin
                bus_write(adr, lfsr_bits(16));
            end
            bus_read(adr, reg_value(adr));
        end

        // bus mode, one frame per write
        base = frame_cnt;
        for (int k = 0; k < N_WR; k++) begin
            rv         = lfsr_bits(16);
            model_word = rv;
            exp_frame  = rv;
            bus_write(ADDR_DAC, rv);
            wait_frames(base + k + 1);
        end
        rv = lfsr_bits(8);
        strobe_gain(rv[7:0]);                     // ignored in bus mode
        idle(IDLE_CYC);
        check_count(base + N_WR);
        bus_read(ADDR_DAC, reg_value(ADDR_DAC));

        // direct mode, gain lands in bits 13 to 6
        en_mmi_ctrl = 1'b0;
        bus_read(ADDR_EN_MMI, reg_value(ADDR_EN_MMI));
        base = frame_cnt;
        for (int k = 0; k < N_STB; k++) begin
            rv               = lfsr_bits(8);
            model_word[13:6] = rv[7:0];
            exp_frame        = model_word;
            strobe_gain(rv[7:0]);
            wait_frames(base + k + 1);
        end
        bus_write(ADDR_DAC, lfsr_bits(16));
        idle(IDLE_CYC);
        check_count(base + N_STB);
        bus_read(ADDR_DAC, reg_value(ADDR_DAC));

        // three writes during one frame merge into one more frame
        en_mmi_ctrl = 1'b1;
        base        = frame_cnt;
        rv          = lfsr_bits(16);
        model_word  = rv;
        exp_frame   = rv;
        bus_write(ADDR_DAC, rv);
        while (spi.sync_n) begin
            idle(1);
        end
        repeat (3) begin
            model_word = lfsr_bits(16);
            bus_write(ADDR_DAC, model_word);
        end
        wait_frames(base + 1);
        exp_frame = model_word;
        wait_frames(base + 2);
        idle(IDLE_CYC);
        check_count(base + 2);

        $display("errors: frame %0d, bus %0d, spi timing %0d", frame_errs, bus_errs, timing_errs);
        if (frame_errs + bus_errs + timing_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYC) @(posedge clk_ifc);
        $display("watchdog expired, the tests did not finish within %0d clock periods", WD_CYC);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+tb
source/dac_ctrl_pkg.sv
source/dac_reg_bank.sv
source/dac_cmd_holder.sv
source/dac_spi_shifter.sv
source/dac_ad5601_ctrl.sv
tb/dac_ad5601_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the DAC control testbench, exit status follows the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dac_ad5601_ctrl_tb -f sim.f -o vsim || exit 1
out=$(./obj_dir/vsim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '>>> PASS' && echo "simulation passed" || { echo "simulation failed"; exit 1; }
